// File: mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    // Primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;

    // Function field of R-type
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        regAddr_t   rs;
        regAddr_t   rt;
        regAddr_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0]  opcode;
        regAddr_t    rs;
        regAddr_t    rt;
        logic [15:0] imm16;
    } iFields;

    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    localparam word_t resetVector = 32'hbfc00000;
    localparam word_t bubbleInstr = 32'h0000_0000; // SLL r0 form that never writes

    // Stage register payloads
    localparam int dRegWidth = $bits(word_t) + $bits(instrWord);
    localparam int eRegWidth = 4 * $bits(word_t) + 3 * $bits(regAddr_t) + $bits(aluOp_t) + 3;
    localparam int wRegWidth = $bits(word_t) + $bits(regAddr_t) + 1;

endpackage

// File: stageReg.sv
module stageReg #(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             stall,
    input  logic             flush,
    input  logic [width-1:0] dIn,
    output logic [width-1:0] dOut
);

    // All-zero contents are a bubble in every stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            dOut <= '0;
        end else if (flush && !stall) begin
            dOut <= '0;
        end else if (!stall) begin
            dOut <= dIn;
        end
    end

endmodule

// File: fetchStage.sv
module fetchStage import mipsPkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  logic  stallF,
    input  logic  branchTaken,
    input  word_t branchTarget,
    output word_t pc,
    output word_t pcPlus4
);

    word_t pcReg;

    assign pc      = pcReg;
    assign pcPlus4 = pcReg + 32'd4;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pcReg <= resetVector;
        end else if (branchTaken) begin
            pcReg <= branchTarget;  // Redirect wins over a fetch stall
        end else if (!stallF) begin
            pcReg <= pcPlus4;
        end
    end

endmodule

// File: regFile.sv
module regFile import mipsPkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  regAddr_t rs,
    input  regAddr_t rt,
    output word_t    rsData,
    output word_t    rtData,
    input  logic     we,
    input  regAddr_t wAddr,
    input  word_t    wData
);

    word_t regs [31:1];  // r0 is not stored

    function automatic word_t readPort(regAddr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (we && addr == wAddr) begin
            val = wData;  // Write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    assign rsData = readPort(rs);
    assign rtData = readPort(rt);

endmodule

// File: decodeStage.sv
module decodeStage import mipsPkg::*; (
    input  instrWord instr,
    input  word_t    pcPlus4,
    output word_t    pcPlus4Out,
    output regAddr_t rs,
    output regAddr_t rt,
    input  word_t    rsData,
    input  word_t    rtData,
    output word_t    opA,
    output word_t    opB,
    output word_t    imm,
    output logic     useImm,
    output aluOp_t   aluOp,
    output regAddr_t dest,
    output logic     regWrite,
    output logic     isBranch
);

    word_t immSext;
    word_t immZext;

    assign immSext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign immZext = {16'h0000, instr.i.imm16};

    assign opA        = rsData;
    assign opB        = rtData;
    assign pcPlus4Out = pcPlus4;  // Carried on for the branch target

    always_comb begin
        rs       = instr.i.rs;
        rt       = instr.i.rt;
        dest     = instr.i.rt;
        imm      = immSext;
        useImm   = 1'b0;
        aluOp    = aluAdd;
        regWrite = 1'b0;
        isBranch = 1'b0;

        case (instr.r.opcode)
            opRType: begin
                dest     = instr.r.rd;
                regWrite = 1'b1;
                case (instr.r.funct)
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: regWrite = 1'b0;  // Includes the bubble
                endcase
            end
            opAddiu: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            opOri: begin
                imm      = immZext;
                useImm   = 1'b1;
                aluOp    = aluOr;
                regWrite = 1'b1;
            end
            opLui: begin
                imm      = immZext;
                useImm   = 1'b1;
                aluOp    = aluLui;
                regWrite = 1'b1;
            end
            opBeq: begin
                isBranch = 1'b1;
                aluOp    = aluSub;
            end
            default: ;
        endcase

        // r0 writes are dropped here so nothing downstream sees them
        if (dest == '0) begin
            regWrite = 1'b0;
        end
    end

endmodule

// File: execStage.sv
module execStage import mipsPkg::*; (
    input  word_t  opA,
    input  word_t  opB,
    input  word_t  imm,
    input  word_t  pcPlus4,
    input  logic   useImm,
    input  logic   isBranch,
    input  aluOp_t aluOp,
    input  logic   forwardA,
    input  logic   forwardB,
    input  word_t  fwdData,
    output word_t  result,
    output logic   branchTaken,
    output word_t  branchTarget
);

    word_t srcA;
    word_t regB;
    word_t srcB;

    assign srcA = forwardA ? fwdData : opA;
    assign regB = forwardB ? fwdData : opB;
    assign srcB = useImm ? imm : regB;

    always_comb begin
        case (aluOp)
            aluAdd:  result = srcA + srcB;
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluSlt:  result = {31'b0, $signed(srcA) < $signed(srcB)};
            aluLui:  result = imm << 16;
            default: result = '0;
        endcase
    end

    // Compare uses the forwarded register values
    assign branchTaken  = isBranch && (srcA == regB);
    assign branchTarget = pcPlus4 + (imm << 2);

endmodule

// File: hazardUnit.sv
module hazardUnit import mipsPkg::*; (
    input  regAddr_t eRs,
    input  regAddr_t eRt,
    input  regAddr_t wDest,
    input  logic     wWrite,
    input  logic     instrValid,
    input  logic     branchTaken,
    output logic     forwardA,
    output logic     forwardB,
    output logic     stallF,
    output logic     flushD,
    output logic     flushE
);

    logic wLive;

    assign wLive = wWrite && (wDest != '0);

    // Only W forwards since older results are already in the register file
    assign forwardA = wLive && (wDest == eRs);
    assign forwardB = wLive && (wDest == eRt);

    assign stallF = !instrValid && !branchTaken;
    assign flushD = !instrValid || branchTaken;  // Missing fetch becomes a bubble
    assign flushE = branchTaken;

endmodule

// File: mipsCore.sv
module mipsCore import mipsPkg::*; (
    input  logic     clk,
    input  logic     resetn,
    output word_t    pc,
    input  word_t    instr,
    input  logic     instrValid,
    output logic     wbEn,
    output regAddr_t wbAddr,
    output word_t    wbData
);

    // Fetch
    word_t fPcPlus4;

    // Decode
    word_t    dPcPlus4, dPcPlus4Out;
    instrWord dInstr;
    regAddr_t dRs, dRt, dDest;
    word_t    dRsData, dRtData, dOpA, dOpB, dImm;
    logic     dUseImm, dRegWrite, dIsBranch;
    aluOp_t   dAluOp;

    // Execute
    word_t      eOpA, eOpB, eImm, ePcPlus4, eResult;
    regAddr_t   eRs, eRt, eDest;
    logic [3:0] eAluOpBits;
    logic       eUseImm, eRegWrite, eIsBranch;

    // Writeback
    word_t    wResult;
    regAddr_t wDest;
    logic     wRegWrite;

    // Control
    logic  branchTaken, forwardA, forwardB, stallF, flushD, flushE;
    word_t branchTarget;

    logic [dRegWidth-1:0] dIn, dOut;
    logic [eRegWidth-1:0] eIn, eOut;
    logic [wRegWidth-1:0] wIn, wOut;

    fetchStage i_fetchStage (
        .clk(clk), .resetn(resetn),
        .stallF(stallF), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .pc(pc), .pcPlus4(fPcPlus4)
    );

    assign dIn = {fPcPlus4, instr};

    stageReg #(.width(dRegWidth)) i_dReg (
        .clk(clk), .resetn(resetn), .stall(1'b0), .flush(flushD), .dIn(dIn), .dOut(dOut)
    );

    assign {dPcPlus4, dInstr} = dOut;

    decodeStage i_decodeStage (
        .instr(dInstr), .pcPlus4(dPcPlus4), .pcPlus4Out(dPcPlus4Out),
        .rs(dRs), .rt(dRt), .rsData(dRsData), .rtData(dRtData),
        .opA(dOpA), .opB(dOpB), .imm(dImm), .useImm(dUseImm), .aluOp(dAluOp),
        .dest(dDest), .regWrite(dRegWrite), .isBranch(dIsBranch)
    );

    regFile i_regFile (
        .clk(clk), .resetn(resetn),
        .rs(dRs), .rt(dRt), .rsData(dRsData), .rtData(dRtData),
        .we(wRegWrite), .wAddr(wDest), .wData(wResult)
    );

    assign eIn = {dOpA, dOpB, dImm, dPcPlus4Out, dRs, dRt, dDest, dAluOp,
                  dUseImm, dRegWrite, dIsBranch};

    stageReg #(.width(eRegWidth)) i_eReg (
        .clk(clk), .resetn(resetn), .stall(1'b0), .flush(flushE), .dIn(eIn), .dOut(eOut)
    );

    assign {eOpA, eOpB, eImm, ePcPlus4, eRs, eRt, eDest, eAluOpBits,
            eUseImm, eRegWrite, eIsBranch} = eOut;

    execStage i_execStage (
        .opA(eOpA), .opB(eOpB), .imm(eImm), .pcPlus4(ePcPlus4),
        .useImm(eUseImm), .isBranch(eIsBranch), .aluOp(aluOp_t'(eAluOpBits)),
        .forwardA(forwardA), .forwardB(forwardB), .fwdData(wResult),
        .result(eResult), .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    assign wIn = {eResult, eDest, eRegWrite};

    stageReg #(.width(wRegWidth)) i_wReg (
        .clk(clk), .resetn(resetn), .stall(1'b0), .flush(1'b0), .dIn(wIn), .dOut(wOut)
    );

    assign {wResult, wDest, wRegWrite} = wOut;

    hazardUnit i_hazardUnit (
        .eRs(eRs), .eRt(eRt), .wDest(wDest), .wWrite(wRegWrite),
        .instrValid(instrValid), .branchTaken(branchTaken),
        .forwardA(forwardA), .forwardB(forwardB),
        .stallF(stallF), .flushD(flushD), .flushE(flushE)
    );

    assign wbEn   = wRegWrite;  // r0 already filtered in decode
    assign wbAddr = wDest;
    assign wbData = wResult;

endmodule

// File: tbClock.sv
module tbClock #(
    parameter int period      = 20,
    parameter int resetCycles = 10
) (
    input  logic restart,
    output logic clk,
    output logic resetn
);

    int count = resetCycles;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset is held low for resetCycles edges at start and after each restart
    always @(posedge clk) begin
        if (restart) begin
            count <= resetCycles;
        end else if (count > 0) begin
            count <= count - 1;
        end
    end

    assign resetn = (count == 0);

endmodule

// File: coreTb.sv
module coreTb import mipsPkg::*; ();

    localparam int romDepth   = 64;
    localparam int maxCycles  = 512;
    localparam int totalInstr = 51;  // Program lengths of all runs
    localparam int numRuns    = 6;
    localparam int watchdogCycles = totalInstr * 4 + numRuns * 40 + 100;

    logic     clk, resetn, restart;
    logic     instrValid, wbEn;
    word_t    pc, instr, romIdx, wbData;
    regAddr_t wbAddr;

    word_t    rom [0:romDepth-1];
    word_t    refRegs [0:31];
    logic     validPat [0:maxCycles-1];
    regAddr_t expAddr [$];
    word_t    expData [$];
    int       expCyc [$];
    int       cyc = 0;
    int       seed = 59533;

    tbClock #(.period(20), .resetCycles(10)) i_tbClock (
        .restart(restart), .clk(clk), .resetn(resetn)
    );

    mipsCore i_mipsCore (
        .clk(clk), .resetn(resetn), .pc(pc), .instr(instr), .instrValid(instrValid),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    assign romIdx = (pc - resetVector) >> 2;
    assign instr  = (romIdx < word_t'(romDepth)) ? rom[romIdx[5:0]] : bubbleInstr;

    always @(posedge clk) begin
        if (!resetn)
            cyc <= 0;  // Cycle 0 is the first one out of reset
        else
            cyc <= cyc + 1;
    end

    task automatic stopWithFailure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic reportProblem(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        stopWithFailure();
    endtask

    task automatic reportMismatch(input string what, input word_t got, input word_t exp);
        $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
        stopWithFailure();
    endtask

    function automatic word_t encodeR(logic [5:0] fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encodeI(logic [5:0] op, regAddr_t rt, regAddr_t rs,
                                      logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic fillRomWithBubbles();
        for (int i = 0; i < romDepth; i++) begin
            rom[i] = bubbleInstr;
        end
    endtask

    // Fetch goes idle before the ROM changes under the running core
    task automatic clearRom();
        @(posedge clk);
        instrValid <= 1'b0;
        @(posedge clk);
        fillRomWithBubbles();
    endtask

    // In-order ISA model that walks the fetch slots given by validPat
    task automatic buildExpected(input int progLen);
        int       idx;
        int       c;
        word_t    ins, a, b, sx, res;
        logic     writes, taken;
        regAddr_t dst;
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        idx = 0;
        c   = 0;
        while (c < maxCycles && idx < progLen) begin
            if (validPat[c[8:0]]) begin
                ins    = rom[idx[5:0]];
                a      = refRegs[ins[25:21]];
                b      = refRegs[ins[20:16]];
                sx     = {{16{ins[15]}}, ins[15:0]};
                res    = '0;
                dst    = ins[20:16];
                writes = 1'b1;
                taken  = 1'b0;
                case (ins[31:26])
                    opRType: begin
                        dst = ins[15:11];
                        case (ins[5:0])
                            fnAddu:  res = a + b;
                            fnSubu:  res = a - b;
                            fnAnd:   res = a & b;
                            fnOr:    res = a | b;
                            fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            default: writes = 1'b0;
                        endcase
                    end
                    opAddiu: res = a + sx;
                    opOri:   res = a | {16'h0000, ins[15:0]};
                    opLui:   res = {ins[15:0], 16'h0000};
                    opBeq: begin
                        writes = 1'b0;
                        taken  = (a == b);
                    end
                    default: writes = 1'b0;
                endcase
                idx = idx + 1;
                if (writes && dst != '0) begin
                    refRegs[dst] = res;
                    expAddr.push_back(dst);
                    expData.push_back(res);
                    expCyc.push_back(c + 3);  // Strobe three cycles after fetch
                end
                if (taken) begin
                    idx = idx + $signed(sx);
                    c   = c + 2;  // Two younger slots are flushed
                end
            end
            c = c + 1;
        end
    endtask

    task automatic runProgram(input string name, input int progLen, input bit randomGaps);
        int c;
        int lastCyc;
        $display("Running %s", name);
        for (int i = 0; i < maxCycles; i++) begin
            validPat[i[8:0]] = (randomGaps && i > 0) ? (($random(seed) & 3) != 0) : (i > 0);
        end
        buildExpected(progLen);
        lastCyc = (expCyc.size() > 0) ? expCyc[expCyc.size() - 1] : 0;
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        @(negedge clk);
        while (!resetn) begin
            @(negedge clk);
        end
        assert (pc == resetVector) else reportMismatch("pc after reset", pc, resetVector);
        assert (!wbEn) else reportProblem("write strobe in the first cycle after reset");
        c = 1;
        while (expAddr.size() > 0 && c <= lastCyc + 1) begin
            @(posedge clk);
            instrValid <= (c < maxCycles) ? validPat[c[8:0]] : 1'b1;
            c = c + 1;
        end
        assert (expAddr.size() == 0) else reportProblem("expected writes were left over");
        repeat (8) begin  // Trailing bubbles must not strobe
            @(posedge clk);
            instrValid <= (c < maxCycles) ? validPat[c[8:0]] : 1'b1;
            c = c + 1;
        end
    endtask

    task automatic testRTypeAlu();
        clearRom();
        rom[0] = encodeI(opLui, 5'd1, 5'd0, 16'hffff);
        rom[1] = encodeI(opOri, 5'd1, 5'd1, 16'h1234);
        rom[2] = encodeI(opAddiu, 5'd2, 5'd0, 16'd100);
        rom[3] = encodeI(opAddiu, 5'd3, 5'd0, 16'd7);
        rom[4] = encodeR(fnAddu, 5'd4, 5'd2, 5'd3);
        rom[5] = encodeR(fnSubu, 5'd5, 5'd3, 5'd2);
        rom[6] = encodeR(fnAnd, 5'd6, 5'd1, 5'd2);
        rom[7] = encodeR(fnOr, 5'd7, 5'd1, 5'd3);
        rom[8] = encodeR(fnSlt, 5'd8, 5'd1, 5'd2);   // Negative below positive
        rom[9] = encodeR(fnSlt, 5'd9, 5'd2, 5'd5);
        runProgram("R-type ALU", 10, 1'b0);
    endtask

    task automatic testImmediates();
        clearRom();
        rom[0] = encodeI(opAddiu, 5'd1, 5'd0, 16'hfffb);
        rom[1] = encodeI(opOri, 5'd2, 5'd0, 16'h8001);  // No sign extension
        rom[2] = encodeI(opLui, 5'd3, 5'd0, 16'h8000);
        rom[3] = encodeI(opAddiu, 5'd4, 5'd3, 16'hffff);
        rom[4] = encodeI(opOri, 5'd5, 5'd1, 16'hf0f0);
        runProgram("immediates", 5, 1'b0);
    endtask

    task automatic testForwarding(input bit gaps);
        clearRom();
        rom[0] = encodeI(opAddiu, 5'd1, 5'd0, 16'd1);
        rom[1] = encodeR(fnAddu, 5'd2, 5'd1, 5'd1);
        rom[2] = encodeR(fnAddu, 5'd3, 5'd2, 5'd1);
        rom[3] = encodeR(fnSubu, 5'd4, 5'd3, 5'd2);
        rom[4] = encodeR(fnSlt, 5'd5, 5'd4, 5'd3);
        rom[5] = encodeI(opAddiu, 5'd4, 5'd4, 16'h7fff);
        runProgram("forwarding", 6, gaps);
    endtask

    task automatic testBranches(input bit gaps);
        clearRom();
        rom[0]  = encodeI(opAddiu, 5'd1, 5'd0, 16'd3);
        rom[1]  = encodeI(opAddiu, 5'd2, 5'd0, 16'd3);
        rom[2]  = encodeI(opBeq, 5'd2, 5'd1, 16'd2);     // Taken to 5
        rom[3]  = encodeI(opAddiu, 5'd3, 5'd0, 16'h11);
        rom[4]  = encodeI(opAddiu, 5'd4, 5'd0, 16'h22);
        rom[5]  = encodeI(opAddiu, 5'd5, 5'd0, 16'h33);
        rom[6]  = encodeI(opBeq, 5'd5, 5'd1, 16'd4);     // Not taken
        rom[7]  = encodeI(opAddiu, 5'd6, 5'd0, 16'h44);
        rom[8]  = encodeR(fnAddu, 5'd0, 5'd1, 5'd2);
        rom[9]  = encodeI(opBeq, 5'd0, 5'd0, 16'd1);     // Taken to 11 after 11 was flushed
        rom[10] = encodeI(opAddiu, 5'd7, 5'd0, 16'h55);
        rom[11] = encodeR(fnAddu, 5'd8, 5'd6, 5'd1);
        runProgram("branches", 12, gaps);
    endtask

    task automatic testRandomGaps();
        testBranches(1'b1);
        testForwarding(1'b1);
    endtask

    // Write port monitor
    always @(negedge clk) begin
        if (resetn && wbEn) begin
            assert (expAddr.size() > 0) else
                reportProblem($sformatf("write strobe to r%0d with no write expected", wbAddr));
            assert (wbAddr == expAddr[0]) else
                reportMismatch("wbAddr", word_t'(wbAddr), word_t'(expAddr[0]));
            assert (wbData == expData[0]) else
                reportMismatch("wbData", wbData, expData[0]);
            assert (cyc == expCyc[0]) else
                reportMismatch("write cycle", word_t'(cyc), word_t'(expCyc[0]));
            expAddr.delete(0);
            expData.delete(0);
            expCyc.delete(0);
        end
    end

    initial begin
        #(watchdogCycles * 20);
        reportProblem("timeout, the expected write strobes did not all arrive");
    end

    initial begin
        instrValid <= 1'b0;
        restart    <= 1'b0;
        fillRomWithBubbles();
        testRTypeAlu();
        testImmediates();
        testForwarding(1'b0);
        testBranches(1'b0);
        testRandomGaps();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module coreTb -f src.f -o coreSim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    cat build.log
    exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: src.f
mipsPkg.sv
stageReg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
execStage.sv
hazardUnit.sv
mipsCore.sv
tbClock.sv
coreTb.sv
